//--- design/alufpu_config.svh
`ifndef ALUFPU_CONFIG_SVH
`define ALUFPU_CONFIG_SVH

// Operand and result width of both datapaths
`define ALUFPU_WORD_BITS 32

// One partial product per cycle, one cycle per multiplier bit
`define ALUFPU_MUL_STEPS 32

// Single-precision 1.0, the true value of a float compare
`define ALUFPU_FP_ONE 32'h3F800000

`endif

//--- design/aluPkg.sv
`default_nettype none

`include "alufpu_config.svh"

package aluPkg;

	typedef logic [`ALUFPU_WORD_BITS-1:0] word_t; // Integer data word

	typedef logic [$clog2(`ALUFPU_WORD_BITS)-1:0] shamt_t; // Low bits of busB

	// Integer operation codes as the decoder issues them
	typedef enum logic [3:0] {
		aluSll = 4'd0,
		aluSrl = 4'd1,
		aluSra = 4'd2,
		aluAdd = 4'd3,
		aluSub = 4'd4,
		aluOr  = 4'd5,
		aluAnd = 4'd6,
		aluXor = 4'd7,
		aluSeq = 4'd8,
		aluSne = 4'd9,
		aluSlt = 4'd10,
		aluSgt = 4'd11,
		aluSle = 4'd12,
		aluSge = 4'd13,
		aluLhi = 4'd14
	} aluOp_e;

endpackage

`default_nettype wire

//--- design/fpuPkg.sv
`default_nettype none

`include "alufpu_config.svh"

package fpuPkg;

	typedef logic [`ALUFPU_WORD_BITS-1:0] fword_t; // Float data word

	// Float operation codes, 6 and 7 unused
	typedef enum logic [3:0] {
		fpEq  = 4'd0,
		fpNe  = 4'd1,
		fpLt  = 4'd2,
		fpGt  = 4'd3,
		fpLe  = 4'd4,
		fpGe  = 4'd5,
		fpMul = 4'd8
	} fpuOp_e;

	// Multiplier sequencing
	typedef enum logic [1:0] {
		mulIdle = 2'd0,
		mulRun  = 2'd1,
		mulDone = 2'd2
	} mulState_e;

	// Wide enough to hold the full step count
	typedef logic [$clog2(`ALUFPU_MUL_STEPS):0] stepCount_t;

endpackage

`default_nettype wire

//--- design/multIf.sv
`timescale 1ns/1ps
`default_nettype none

interface multIf;

	logic start; // One-cycle request
	fpuPkg::fword_t operandA; // Multiplicand
	fpuPkg::fword_t operandB; // Multiplier
	logic busy; // High for the whole run
	fpuPkg::fword_t product; // Low word of the product

	modport issuer (
		output start,
		output operandA,
		output operandB,
		input  busy,
		input  product
	);

	modport engine (
		input  start,
		input  operandA,
		input  operandB,
		output busy,
		output product
	);

endinterface

`default_nettype wire

//--- design/integerAlu.sv
`timescale 1ns/1ps
`default_nettype none

`include "alufpu_config.svh"

module integerAlu (
	input  wire aluPkg::word_t  busA,
	input  wire aluPkg::word_t  busB,
	input  wire aluPkg::aluOp_e aluOp,
	output aluPkg::word_t       aluResult,
	output logic                gpBranch
);

	localparam int HalfBits = `ALUFPU_WORD_BITS / 2;

	aluPkg::shamt_t shamt;
	logic eqFlag;
	logic ltFlag;
	logic gtFlag;
	logic [HalfBits-1:0] immHalf;

	// Shift amount from the low bits only
	assign shamt = busB[$bits(aluPkg::shamt_t)-1:0];

	// Both buses treated as unsigned
	assign eqFlag = (busA == busB);
	assign ltFlag = (busA < busB);
	assign gtFlag = (busA > busB);

	assign immHalf = busB[HalfBits-1:0]; // Immediate for lhi

	always_comb begin
		case (aluOp)
			aluPkg::aluSll: begin
				aluResult = busA << shamt;
			end
			aluPkg::aluSrl: begin
				aluResult = busA >> shamt;
			end
			aluPkg::aluSra: begin
				aluResult = aluPkg::word_t'($signed(busA) >>> shamt); // Sign fills from the top
			end
			aluPkg::aluAdd: begin
				aluResult = busA + busB;
			end
			aluPkg::aluSub: begin
				aluResult = busA - busB;
			end
			aluPkg::aluOr: begin
				aluResult = busA | busB;
			end
			aluPkg::aluAnd: begin
				aluResult = busA & busB;
			end
			aluPkg::aluXor: begin
				aluResult = busA ^ busB;
			end
			aluPkg::aluSeq: begin
				aluResult = aluPkg::word_t'(eqFlag);
			end
			aluPkg::aluSne: begin
				aluResult = aluPkg::word_t'(!eqFlag);
			end
			aluPkg::aluSlt: begin
				aluResult = aluPkg::word_t'(ltFlag);
			end
			aluPkg::aluSgt: begin
				aluResult = aluPkg::word_t'(gtFlag);
			end
			aluPkg::aluSle: begin
				aluResult = aluPkg::word_t'(!gtFlag);
			end
			aluPkg::aluSge: begin
				aluResult = aluPkg::word_t'(!ltFlag);
			end
			aluPkg::aluLhi: begin
				aluResult = {immHalf, {HalfBits{1'b0}}}; // Upper half, zeros below
			end
			default: begin
				aluResult = '0; // Code 15
			end
		endcase
	end

	// Set-on-compare results land in bit 0, so branches test that bit
	assign gpBranch = aluResult[0];

endmodule

`default_nettype wire

//--- design/iterativeMultiplier.sv
`timescale 1ns/1ps
`default_nettype none

`include "alufpu_config.svh"

module iterativeMultiplier (
	input wire clock,
	input wire arstN,
	multIf.engine mult
);

	localparam int IndexBits = $clog2(`ALUFPU_WORD_BITS);

	fpuPkg::mulState_e state;
	fpuPkg::mulState_e nextState;
	fpuPkg::stepCount_t step;
	fpuPkg::stepCount_t nextStep;
	fpuPkg::fword_t multiplicand;
	fpuPkg::fword_t multiplier;
	fpuPkg::fword_t accum;
	fpuPkg::fword_t partial;
	logic [IndexBits-1:0] bitIndex;
	logic accept;
	logic lastStep;

	// Requests while running are dropped
	assign accept = mult.start && (state != fpuPkg::mulRun);

	assign nextStep = step + 1'b1;
	assign lastStep = (nextStep == fpuPkg::stepCount_t'(`ALUFPU_MUL_STEPS));

	// Step index picks the multiplier bit and the shift
	assign bitIndex = step[IndexBits-1:0];
	assign partial = multiplier[bitIndex] ? (multiplicand << bitIndex) : '0;

	always_comb begin
		nextState = state;
		case (state)
			fpuPkg::mulIdle, fpuPkg::mulDone: begin
				if (mult.start) begin
					nextState = fpuPkg::mulRun;
				end
			end
			fpuPkg::mulRun: begin
				if (lastStep) begin
					nextState = fpuPkg::mulDone; // Product stays in accum
				end
			end
			default: begin
				nextState = fpuPkg::mulIdle;
			end
		endcase
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			state <= fpuPkg::mulIdle;
			step <= '0;
			accum <= '0;
		end else begin
			state <= nextState;
			if (accept) begin
				step <= '0;
				accum <= '0;
			end else if (state == fpuPkg::mulRun) begin
				step <= nextStep;
				accum <= accum + partial; // Low word only, carries out are lost
			end
		end
	end

	// Operands held for the run so the buses may change
	always_ff @(posedge clock) begin
		if (accept) begin
			multiplicand <= mult.operandA;
			multiplier <= mult.operandB;
		end
	end

	assign mult.busy = (state == fpuPkg::mulRun);
	assign mult.product = accum;

endmodule

`default_nettype wire

//--- design/fpuUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "alufpu_config.svh"

module fpuUnit (
	input  wire clock,
	input  wire arstN,
	input  wire fpuPkg::fword_t fbusA,
	input  wire fpuPkg::fword_t fbusB,
	input  wire fpuPkg::fpuOp_e fpuOp,
	multIf.issuer mult,
	output fpuPkg::fword_t fpuResult
);

	fpuPkg::fpuOp_e prevOp;
	logic eqFlag;
	logic ltFlag;
	logic gtFlag;

	// Compare outcome as a float word
	function automatic fpuPkg::fword_t boolToFloat(input logic flag);
		fpuPkg::fword_t oneWord;
		oneWord = `ALUFPU_FP_ONE;
		return flag ? oneWord : '0;
	endfunction

	// Raw bit patterns compared as unsigned
	assign eqFlag = (fbusA == fbusB);
	assign ltFlag = (fbusA < fbusB);
	assign gtFlag = (fbusA > fbusB);

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			prevOp <= fpuPkg::fpEq;
		end else begin
			prevOp <= fpuOp;
		end
	end

	// Pulse on entry into fpMul only
	assign mult.start = (fpuOp == fpuPkg::fpMul) && (prevOp != fpuPkg::fpMul);
	assign mult.operandA = fbusA;
	assign mult.operandB = fbusB;

	always_comb begin
		case (fpuOp)
			fpuPkg::fpEq: begin
				fpuResult = boolToFloat(eqFlag);
			end
			fpuPkg::fpNe: begin
				fpuResult = boolToFloat(!eqFlag);
			end
			fpuPkg::fpLt: begin
				fpuResult = boolToFloat(ltFlag);
			end
			fpuPkg::fpGt: begin
				fpuResult = boolToFloat(gtFlag);
			end
			fpuPkg::fpLe: begin
				fpuResult = boolToFloat(!gtFlag);
			end
			fpuPkg::fpGe: begin
				fpuResult = boolToFloat(!ltFlag);
			end
			fpuPkg::fpMul: begin
				fpuResult = mult.product; // Valid once busy drops
			end
			default: begin
				fpuResult = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- design/alufpu.sv
`timescale 1ns/1ps
`default_nettype none

module alufpu (
	input  wire clock,
	input  wire arstN,
	input  wire aluPkg::word_t  busA,
	input  wire aluPkg::word_t  busB,
	input  wire aluPkg::aluOp_e aluOp,
	input  wire fpuPkg::fword_t fbusA,
	input  wire fpuPkg::fword_t fbusB,
	input  wire fpuPkg::fpuOp_e fpuOp,
	output aluPkg::word_t       aluResult,
	output fpuPkg::fword_t      fpuResult,
	output logic                multStall,
	output logic                gpBranch
);

	multIf multBus ();

	// Integer side, purely combinational
	integerAlu aluI (
		.busA      (busA),
		.busB      (busB),
		.aluOp     (aluOp),
		.aluResult (aluResult),
		.gpBranch  (gpBranch)
	);

	fpuUnit fpuI (
		.clock     (clock),
		.arstN     (arstN),
		.fbusA     (fbusA),
		.fbusB     (fbusB),
		.fpuOp     (fpuOp),
		.mult      (multBus.issuer),
		.fpuResult (fpuResult)
	);

	iterativeMultiplier multI (
		.clock (clock),
		.arstN (arstN),
		.mult  (multBus.engine)
	);

	// Pipeline holds while the multiplier runs
	assign multStall = multBus.busy;

endmodule

`default_nettype wire

//--- testbench/alufpuTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "alufpu_config.svh"

module alufpuTb;

	typedef struct packed {
		logic [3:0]  op;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] want;
	} aluVector_t;

	typedef struct packed {
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] want;
	} mulVector_t;

	localparam int AluCount = 29;
	localparam int MulCount = 6;
	localparam int CmpCount = 6;
	localparam int RandCount = 10;
	localparam int CycleLimit = (AluCount + CmpCount * 3 + MulCount + RandCount) * 40 + 100;

	// Pairs are equal, A greater, A smaller as unsigned patterns
	localparam logic [31:0] PairA [3] = '{32'h3F800000, 32'hBF800000, 32'h00000001};
	localparam logic [31:0] PairB [3] = '{32'h3F800000, 32'h3F800000, 32'h40000000};
	localparam fpuPkg::fpuOp_e CmpOps [CmpCount] = '{fpuPkg::fpEq, fpuPkg::fpNe,
		fpuPkg::fpLt, fpuPkg::fpGt, fpuPkg::fpLe, fpuPkg::fpGe};
	// Bit 2 for the equal pair, bit 0 for the smaller pair
	localparam logic [2:0] CmpTruth [CmpCount] = '{3'b100, 3'b011, 3'b001, 3'b010, 3'b101, 3'b110};

	logic clock;
	logic arstN;
	aluPkg::word_t busA;
	aluPkg::word_t busB;
	aluPkg::aluOp_e aluOp;
	fpuPkg::fword_t fbusA;
	fpuPkg::fword_t fbusB;
	fpuPkg::fpuOp_e fpuOp;
	aluPkg::word_t aluResult;
	fpuPkg::fword_t fpuResult;
	logic multStall;
	logic gpBranch;

	aluVector_t aluTable [AluCount];
	mulVector_t mulTable [MulCount];
	logic [31:0] lfsrState;
	int cycleCount = 0;
	int testCount;
	int failedTests;
	int testErrors;
	int totalErrors;

	alufpu dut_i (
		.clock     (clock),
		.arstN     (arstN),
		.busA      (busA),
		.busB      (busB),
		.aluOp     (aluOp),
		.fbusA     (fbusA),
		.fbusB     (fbusB),
		.fpuOp     (fpuOp),
		.aluResult (aluResult),
		.fpuResult (fpuResult),
		.multStall (multStall),
		.gpBranch  (gpBranch)
	);

	always #4 clock = ~clock;

	always @(posedge clock) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= CycleLimit) begin
			$display("timeout: the run did not finish within %0d clock cycles", CycleLimit);
			$display("** FAIL **");
			$finish;
		end
	end

	task automatic fillTables();
		aluTable[0] = '{aluPkg::aluSll, 32'h00000001, 32'h00000010, 32'h00010000};
		aluTable[1] = '{aluPkg::aluSll, 32'h000000FF, 32'h0000003F, 32'h80000000};
		aluTable[2] = '{aluPkg::aluSrl, 32'h80000000, 32'h00000014, 32'h00000800};
		aluTable[3] = '{aluPkg::aluSra, 32'h80000000, 32'h00000010, 32'hFFFF8000};
		aluTable[4] = '{aluPkg::aluSra, 32'hF000000F, 32'h00000024, 32'hFF000000};
		aluTable[5] = '{aluPkg::aluSra, 32'h7FFFFFFF, 32'h00000011, 32'h00003FFF};
		aluTable[6] = '{aluPkg::aluAdd, 32'hFFFFFFFF, 32'h00000002, 32'h00000001};
		aluTable[7] = '{aluPkg::aluSub, 32'h00000005, 32'h00000007, 32'hFFFFFFFE};
		aluTable[8] = '{aluPkg::aluOr, 32'hF0F00000, 32'h0F0F0001, 32'hFFFF0001};
		aluTable[9] = '{aluPkg::aluAnd, 32'hFF00FF00, 32'h0FF00FF0, 32'h0F000F00};
		aluTable[10] = '{aluPkg::aluXor, 32'hAAAA5555, 32'hFFFF0000, 32'h55555555};
		aluTable[11] = '{aluPkg::aluSeq, 32'h00001234, 32'h00001234, 32'h00000001};
		aluTable[12] = '{aluPkg::aluSeq, 32'h80001234, 32'h00001234, 32'h00000000};
		aluTable[13] = '{aluPkg::aluSne, 32'h00001234, 32'h00001234, 32'h00000000};
		aluTable[14] = '{aluPkg::aluSne, 32'h00001234, 32'h00001235, 32'h00000001};
		aluTable[15] = '{aluPkg::aluSlt, 32'h00000001, 32'h80000000, 32'h00000001};
		aluTable[16] = '{aluPkg::aluSlt, 32'h80000000, 32'h00000001, 32'h00000000};
		aluTable[17] = '{aluPkg::aluSlt, 32'h00000009, 32'h00000009, 32'h00000000};
		aluTable[18] = '{aluPkg::aluSgt, 32'hFFFFFFFF, 32'h00000001, 32'h00000001};
		aluTable[19] = '{aluPkg::aluSgt, 32'h00000001, 32'hFFFFFFFF, 32'h00000000};
		aluTable[20] = '{aluPkg::aluSgt, 32'h00000009, 32'h00000009, 32'h00000000};
		aluTable[21] = '{aluPkg::aluSle, 32'h00000005, 32'h00000005, 32'h00000001};
		aluTable[22] = '{aluPkg::aluSle, 32'h00000006, 32'h00000005, 32'h00000000};
		aluTable[23] = '{aluPkg::aluSle, 32'h00000001, 32'h80000000, 32'h00000001};
		aluTable[24] = '{aluPkg::aluSge, 32'h80000000, 32'h7FFFFFFF, 32'h00000001};
		aluTable[25] = '{aluPkg::aluSge, 32'h00000003, 32'h00000004, 32'h00000000};
		aluTable[26] = '{aluPkg::aluSge, 32'h00000004, 32'h00000004, 32'h00000001};
		aluTable[27] = '{aluPkg::aluLhi, 32'hDEADBEEF, 32'hFFFFABCD, 32'hABCD0000};
		aluTable[28] = '{4'hF, 32'h00001234, 32'h00000001, 32'h00000000}; // Unused code
		mulTable[0] = '{32'h00000000, 32'h12345678, 32'h00000000};
		mulTable[1] = '{32'h00000001, 32'hDEADBEEF, 32'hDEADBEEF};
		mulTable[2] = '{32'hFFFFFFFF, 32'hFFFFFFFF, 32'h00000001};
		mulTable[3] = '{32'h00010000, 32'h00010001, 32'h00010000}; // Carry past bit 31 dropped
		mulTable[4] = '{32'hFFFFFFFF, 32'h00000002, 32'hFFFFFFFE};
		mulTable[5] = '{32'h12345678, 32'h00000010, 32'h23456780};
	endtask

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] state);
		logic feedback;
		feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], feedback};
	endfunction

	task automatic drawWord(output logic [31:0] word);
		word = '0;
		for (int i = 0; i < 32; i++) begin
			lfsrState = lfsrNext(lfsrState);
			word = {word[30:0], lfsrState[0]};
		end
	endtask

	task automatic matchWord(input string what, input logic [31:0] got, input logic [31:0] want);
		assert (got === want) else begin
			$display("error at %0t ns: %s is %h, expected %h", $time, what, got, want);
			testErrors++;
		end
	endtask

	task automatic finishTest(input string name);
		testCount++;
		if (testErrors == 0) begin
			$display("test %0d %s: ok", testCount, name);
		end else begin
			$display("test %0d %s: %0d mismatches", testCount, name, testErrors);
			failedTests++;
			totalErrors += testErrors;
		end
		testErrors = 0;
	endtask

	task automatic driveAlu(input int idx);
		busA <= aluTable[idx].a;
		busB <= aluTable[idx].b;
		aluOp <= aluPkg::aluOp_e'(aluTable[idx].op);
	endtask

	task automatic verifyAlu(input int idx);
		matchWord($sformatf("aluResult of entry %0d", idx), aluResult, aluTable[idx].want);
		matchWord($sformatf("gpBranch of entry %0d", idx), 32'(gpBranch),
			32'(aluTable[idx].want[0]));
	endtask

	// Equal pair, so a code decoded as fpEq would show 1.0
	task automatic unusedFloatCode();
		@(posedge clock);
		fbusA <= PairA[0];
		fbusB <= PairB[0];
		fpuOp <= fpuPkg::fpuOp_e'(4'd7);
		@(negedge clock);
		matchWord("fpuResult of unused code", fpuResult, 32'h0);
		finishTest("unused fpu code");
	endtask

	task automatic floatCompares(input int idx);
		fpuPkg::fpuOp_e op;
		logic [31:0] want;
		op = CmpOps[idx];
		for (int p = 0; p < 3; p++) begin
			@(posedge clock);
			fbusA <= PairA[p];
			fbusB <= PairB[p];
			fpuOp <= op;
			@(negedge clock);
			want = CmpTruth[idx][2 - p] ? `ALUFPU_FP_ONE : 32'h0;
			matchWord($sformatf("fpuResult of %s pair %0d", op.name(), p), fpuResult, want);
		end
		finishTest($sformatf("compare %s", op.name()));
	endtask

	task automatic multiplyPair(input logic [31:0] a, input logic [31:0] b,
		input logic [31:0] want, input string name);
		int stallCycles;
		int aluIdx;
		stallCycles = 0;
		aluIdx = 0;
		@(posedge clock);
		fbusA <= a;
		fbusB <= b;
		fpuOp <= fpuPkg::fpMul;
		@(posedge clock); // Operands captured here
		@(negedge clock);
		matchWord("multStall after start", 32'(multStall), 32'h1);
		while (multStall === 1'b1) begin
			stallCycles++;
			@(posedge clock);
			fbusA <= ~a; // Bus changes mid-run
			fbusB <= a ^ b;
			driveAlu(aluIdx);
			@(negedge clock);
			verifyAlu(aluIdx);
			aluIdx = (aluIdx + 1) % AluCount;
		end
		matchWord("multStall cycle count", stallCycles, `ALUFPU_MUL_STEPS);
		matchWord("product", fpuResult, want);
		finishTest(name);
		@(posedge clock);
		fpuOp <= fpuPkg::fpEq;
	endtask

	initial begin
		logic [31:0] randA;
		logic [31:0] randB;
		fillTables();
		lfsrState = 32'd3;
		testCount = 0;
		failedTests = 0;
		testErrors = 0;
		totalErrors = 0;
		clock = 1'b0;
		arstN = 1'b0;
		busA = '0;
		busB = '0;
		aluOp = aluPkg::aluSll;
		fbusA = '0;
		fbusB = '0;
		fpuOp = fpuPkg::fpEq;
		repeat (4) @(posedge clock);
		arstN <= 1'b1;
		@(negedge clock);
		matchWord("multStall after reset", 32'(multStall), 32'h0);
		finishTest("reset");
		for (int i = 0; i < AluCount; i++) begin
			@(posedge clock);
			driveAlu(i);
			@(negedge clock);
			verifyAlu(i);
			finishTest($sformatf("alu entry %0d", i));
		end
		unusedFloatCode();
		for (int i = 0; i < CmpCount; i++) begin
			floatCompares(i);
		end
		for (int i = 0; i < MulCount; i++) begin
			multiplyPair(mulTable[i].a, mulTable[i].b, mulTable[i].want,
				$sformatf("multiply entry %0d", i));
		end
		for (int i = 0; i < RandCount; i++) begin
			drawWord(randA);
			drawWord(randB);
			multiplyPair(randA, randB, randA * randB, $sformatf("random multiply %0d", i));
		end
		$display("tests run %0d, failed %0d, mismatches %0d", testCount, failedTests, totalErrors);
		if (failedTests == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- alufpu.f
+incdir+design
design/aluPkg.sv
design/fpuPkg.sv
design/multIf.sv
design/integerAlu.sv
design/iterativeMultiplier.sv
design/fpuUnit.sv
design/alufpu.sv
testbench/alufpuTb.sv

//--- Makefile
# Verilator build and run for the alufpu testbench

VERILATOR ?= verilator
TOP       ?= alufpuTb
FILELIST  ?= alufpu.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard design/*.sv design/*.svh testbench/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides the result, so a missing pass line fails the target
run: compile
	./$(SIM_BIN) | tee $(LOG)
	@grep -q '^\*\* PASS \*\*$$' $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
